// File: rtl/pcxt_consts.svh
// Shared counts, luma weights and widths for the PC/XT glue RTL and bench, pulled in by `include
`ifndef PCXT_CONSTS_SVH
`define PCXT_CONSTS_SVH

// System reset hold after the last request, in CLK_50M cycles
`define RESET_HOLD_CYCLES 65535

// Extra CPU reset hold once system reset is gone
`define CPU_RESET_DELAY 42

// One second of splash screen at 50 MHz
`define SPLASH_TICKS_PER_SEC 50000000

// Splash screen length in whole seconds
`define SPLASH_SECONDS 5

// Luma weights in 1/256 units, sum is 255
`define LUMA_WEIGHT_R 54
`define LUMA_WEIGHT_G 183
`define LUMA_WEIGHT_B 18

// Pixel width from the video core, and board VGA width
`define COLOR_BITS 6
`define VGA_BITS 8

`endif

// File: rtl/pcxt_system_pkg.sv
// System-side types for host options, reset state and audio samples, referenced by package scope
package pcxt_system_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Host options
	////////////////////////////////////////////////////////////////////////////

	// Video output select, status bits 4:3
	typedef enum logic [1:0] {
		cga   = 2'd0,
		tandy = 2'd1,
		mda   = 2'd2
	} video_output_e;

	// Decoded status word, MSB first
	typedef struct packed {
		logic [1:0]    aspect;      // Bits 9:8
		logic          splash_skip; // Bit 7
		video_output_e video_mode;  // Bits 4:3
		logic [1:0]    tint_mode;   // Bits 2:1
		logic          reset_req;   // Bit 0
	} pcxt_options_t;

	////////////////////////////////////////////////////////////////////////////
	// Reset state
	////////////////////////////////////////////////////////////////////////////

	// All three levels are high right after reset_wire
	typedef struct packed {
		logic sys_reset;
		logic cpu_reset;
		logic splash_active;
	} reset_state_t;

	// Signed board audio word
	typedef logic signed [15:0] audio_sample_t;

	// Raw sound sources ahead of the mixer
	typedef struct packed {
		audio_sample_t opl2;    // AdLib, signed
		logic          speaker; // PC speaker bit
		logic [7:0]    tandy;   // Tandy sound, unsigned
	} audio_sources_t;

endpackage

// File: rtl/pcxt_video_pkg.sv
// Video-side types for pixels, sync, monitor tint and VGA outputs, referenced by package scope
`include "pcxt_consts.svh"

package pcxt_video_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Pixel side
	////////////////////////////////////////////////////////////////////////////

	// Core pixel, one field per channel
	typedef struct packed {
		logic [`COLOR_BITS-1:0] r;
		logic [`COLOR_BITS-1:0] g;
		logic [`COLOR_BITS-1:0] b;
	} pixel_t;

	// Display enable and syncs travel together
	typedef struct packed {
		logic de;
		logic hs;
		logic vs;
	} video_sync_t;

	// Monitor emulation, status bits 2:1
	typedef enum logic [1:0] {
		color = 2'd0,
		green = 2'd1,
		amber = 2'd2,
		mono  = 2'd3
	} tint_e;

	////////////////////////////////////////////////////////////////////////////
	// Board side
	////////////////////////////////////////////////////////////////////////////

	// Full VGA word with its sync
	typedef struct packed {
		logic [`VGA_BITS-1:0] r;
		logic [`VGA_BITS-1:0] g;
		logic [`VGA_BITS-1:0] b;
		video_sync_t          sync;
	} vga_out_t;

endpackage

// File: rtl/host_input_stage.sv
// Input stage that registers the decoded host options and synchronises the PS/2 keyboard lines
`timescale 1ns/10ps

module host_input_stage (
	input  logic                           CLK_50M,
	input  logic                           reset_wire,
	input  logic [31:0]                    status,
	input  logic                           ps2_clk,
	input  logic                           ps2_data,
	output pcxt_system_pkg::pcxt_options_t options,
	output logic                           ps2_clk_sync,
	output logic                           ps2_data_sync
);

	// First PS/2 flops, may go metastable
	logic ps2_clk_meta;
	logic ps2_data_meta;

	// Options pulled out of the status word
	pcxt_system_pkg::pcxt_options_t options_dec;

	// Field decode
	always_comb begin
		options_dec.reset_req   = status[0];
		options_dec.tint_mode   = status[2:1];
		options_dec.video_mode  = pcxt_system_pkg::video_output_e'(status[4:3]);
		options_dec.splash_skip = status[7];
		options_dec.aspect      = status[9:8];
	end

	// Option register, cleared to colour CGA at 4:3
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			options <= '0;
		end else begin
			options <= options_dec;
		end
	end

	// Two-flop sync on both keyboard lines
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			ps2_clk_meta  <= 1'b0;
			ps2_clk_sync  <= 1'b0;
			ps2_data_meta <= 1'b0;
			ps2_data_sync <= 1'b0;
		end else begin
			ps2_clk_meta  <= ps2_clk;
			ps2_clk_sync  <= ps2_clk_meta;
			ps2_data_meta <= ps2_data;
			ps2_data_sync <= ps2_data_meta;
		end
	end

endmodule

// File: rtl/power_on_sequencer.sv
// Power-on sequencer giving system reset, delayed CPU reset and the splash screen timer
`timescale 1ns/10ps
`include "pcxt_consts.svh"

module power_on_sequencer #(
	parameter int hold_cycles   = `RESET_HOLD_CYCLES,
	parameter int ticks_per_sec = `SPLASH_TICKS_PER_SEC
) (
	input  logic                           CLK_50M,
	input  logic                           reset_wire,
	input  pcxt_system_pkg::pcxt_options_t options,
	output logic                           sys_reset,
	output logic                           cpu_reset,
	output logic                           splash_active
);

	// Terminal counts, degenerate values collapse to a single cycle
	localparam int hold_last  = (hold_cycles > 1) ? hold_cycles - 1 : 0;
	localparam int tick_last  = (ticks_per_sec > 1) ? ticks_per_sec - 1 : 0;
	localparam int sec_last   = `SPLASH_SECONDS - 1;
	localparam int delay_last = `CPU_RESET_DELAY - 1;

	// Counter widths
	localparam int hold_bits  = (hold_last > 0) ? $clog2(hold_last + 1) : 1;
	localparam int tick_bits  = (tick_last > 0) ? $clog2(tick_last + 1) : 1;
	localparam int sec_bits   = $clog2(`SPLASH_SECONDS + 1);
	localparam int delay_bits = $clog2(`CPU_RESET_DELAY + 1);

	pcxt_system_pkg::reset_state_t state;
	logic [tick_bits-1:0]          tick_cnt;
	logic [sec_bits-1:0]           sec_cnt;
	logic [hold_bits-1:0]          hold_cnt;
	logic [delay_bits-1:0]         delay_cnt;
	logic                          reset_request;

	// Host reset bit, or splash still running
	assign reset_request = options.reset_req | state.splash_active;

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			state     <= '1;
			tick_cnt  <= '0;
			sec_cnt   <= '0;
			hold_cnt  <= '0;
			delay_cnt <= '0;
		end else begin
			////////////////////////////////////////////////////////////////////
			// Splash timer
			////////////////////////////////////////////////////////////////////
			if (state.splash_active) begin
				if (options.splash_skip) begin
					state.splash_active <= 1'b0;
				end else if (tick_cnt == tick_bits'(tick_last)) begin
					// Whole second done
					tick_cnt <= '0;
					if (sec_cnt == sec_bits'(sec_last)) begin
						state.splash_active <= 1'b0;
					end else begin
						sec_cnt <= sec_cnt + 1'b1;
					end
				end else begin
					tick_cnt <= tick_cnt + 1'b1;
				end
			end

			////////////////////////////////////////////////////////////////////
			// System reset hold
			////////////////////////////////////////////////////////////////////
			if (reset_request) begin
				state.sys_reset <= 1'b1;
				hold_cnt        <= '0;
			end else if (state.sys_reset) begin
				if (hold_cnt == hold_bits'(hold_last)) begin
					state.sys_reset <= 1'b0;
				end else begin
					hold_cnt <= hold_cnt + 1'b1;
				end
			end

			// CPU reset trails system reset
			if (state.sys_reset) begin
				state.cpu_reset <= 1'b1;
				delay_cnt       <= '0;
			end else if (state.cpu_reset) begin
				if (delay_cnt == delay_bits'(delay_last)) begin
					state.cpu_reset <= 1'b0;
				end else begin
					delay_cnt <= delay_cnt + 1'b1;
				end
			end
		end
	end

	assign sys_reset     = state.sys_reset;
	assign cpu_reset     = state.cpu_reset;
	assign splash_active = state.splash_active;

endmodule

// File: rtl/luma_tint.sv
// CGA monitor emulation producing colour, green, amber or mono pixels, with MDA pixels bypassed
`timescale 1ns/10ps
`include "pcxt_consts.svh"

module luma_tint (
	input  logic                           CLK_50M,
	input  logic                           reset_wire,
	input  pcxt_video_pkg::pixel_t         pixel,
	input  pcxt_video_pkg::video_sync_t    sync,
	input  pcxt_system_pkg::pcxt_options_t options,
	output pcxt_video_pkg::pixel_t         pixel_out,
	output pcxt_video_pkg::video_sync_t    sync_out
);

	localparam int levels = 2 ** `COLOR_BITS;

	// Per-channel luma terms, indexed by channel value
	logic [`COLOR_BITS-1:0] red_lut   [levels];
	logic [`COLOR_BITS-1:0] green_lut [levels];
	logic [`COLOR_BITS-1:0] blue_lut  [levels];

	logic [`COLOR_BITS-1:0] luma;
	logic                   mda_mode;
	pcxt_video_pkg::tint_e  tint;
	pcxt_video_pkg::pixel_t tinted;

	// Term is value times weight, rounded, over 256
	for (genvar i = 0; i < levels; i++) begin : g_lut
		assign red_lut[i]   = `COLOR_BITS'((i * `LUMA_WEIGHT_R + 127) >> 8);
		assign green_lut[i] = `COLOR_BITS'((i * `LUMA_WEIGHT_G + 127) >> 8);
		assign blue_lut[i]  = `COLOR_BITS'((i * `LUMA_WEIGHT_B + 127) >> 8);
	end

	// Peak sum is 62, no carry out
	assign luma = red_lut[pixel.r] + green_lut[pixel.g] + blue_lut[pixel.b];

	assign mda_mode = (options.video_mode == pcxt_system_pkg::mda);
	assign tint     = pcxt_video_pkg::tint_e'(options.tint_mode);

	// Tint select
	always_comb begin
		tinted = pixel;
		if (!mda_mode) begin
			case (tint)
				pcxt_video_pkg::green: begin
					tinted.r = '0;
					tinted.g = luma;
					tinted.b = '0;
				end
				pcxt_video_pkg::amber: begin
					// Half green gives the orange cast
					tinted.r = luma;
					tinted.g = luma >> 1;
					tinted.b = '0;
				end
				pcxt_video_pkg::mono: begin
					tinted.r = luma;
					tinted.g = luma;
					tinted.b = luma;
				end
				default: tinted = pixel;
			endcase
		end
	end

	// Pixel pipe
	always_ff @(posedge CLK_50M) begin
		pixel_out <= tinted;
	end

	// Sync pipe, blanked in reset
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			sync_out <= '0;
		end else begin
			sync_out <= sync;
		end
	end

endmodule

// File: rtl/audio_mixer.sv
// Signed mixer adding the AdLib, PC speaker and Tandy sources into one registered 17-bit sum
`timescale 1ns/10ps

module audio_mixer (
	input  logic                            CLK_50M,
	input  logic                            reset_wire,
	input  pcxt_system_pkg::audio_sources_t sources,
	output logic signed [16:0]              mix
);

	logic signed [16:0] opl2_term;
	logic signed [16:0] speaker_term;
	logic signed [16:0] tandy_term;
	logic signed [16:0] mix_sum;

	// AdLib sign-extended, times 4
	assign opl2_term = {sources.opl2[15], sources.opl2} << 2;

	// Speaker bit worth 32768
	assign speaker_term = {1'b0, sources.speaker, 15'd0};

	// Tandy unsigned, times 64
	assign tandy_term = {3'b000, sources.tandy, 6'd0};

	// Wraps at 17 bits
	assign mix_sum = opl2_term + speaker_term + tandy_term;

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			mix <= '0;
		end else begin
			mix <= mix_sum;
		end
	end

endmodule

// File: rtl/av_output_stage.sv
// Output stage registering VGA and audio board outputs and deriving the HDMI aspect ratio
`timescale 1ns/10ps
`include "pcxt_consts.svh"

module av_output_stage (
	input  logic                           CLK_50M,
	input  logic                           reset_wire,
	input  pcxt_video_pkg::pixel_t         pixel,
	input  pcxt_video_pkg::video_sync_t    sync,
	input  logic signed [16:0]             mix,
	input  pcxt_system_pkg::pcxt_options_t options,
	output pcxt_video_pkg::vga_out_t       vga,
	output pcxt_system_pkg::audio_sample_t audio_l,
	output pcxt_system_pkg::audio_sample_t audio_r,
	output logic [12:0]                    video_arx,
	output logic [12:0]                    video_ary
);

	// Zero LSBs from 6 to 8 bits
	localparam int pad_bits = `VGA_BITS - `COLOR_BITS;

	pcxt_video_pkg::vga_out_t       vga_next;
	pcxt_system_pkg::audio_sample_t audio_next;
	logic [12:0]                    arx_next;
	logic [12:0]                    ary_next;

	always_comb begin
		vga_next.r    = {pixel.r, {pad_bits{1'b0}}};
		vga_next.g    = {pixel.g, {pad_bits{1'b0}}};
		vga_next.b    = {pixel.b, {pad_bits{1'b0}}};
		vga_next.sync = sync;
		// Halved mix fits 16 bits
		audio_next    = mix[16:1];
		// Field 0 is 4:3, others pick a scaler preset
		if (options.aspect == 2'd0) begin
			arx_next = 13'd4;
			ary_next = 13'd3;
		end else begin
			arx_next = 13'(options.aspect - 2'd1);
			ary_next = '0;
		end
	end

	// Board outputs, reset to blank, silent and 4:3
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			vga       <= '0;
			audio_l   <= '0;
			audio_r   <= '0;
			video_arx <= 13'd4;
			video_ary <= 13'd3;
		end else begin
			vga       <= vga_next;
			audio_l   <= audio_next;
			audio_r   <= audio_next;
			video_arx <= arx_next;
			video_ary <= ary_next;
		end
	end

endmodule

// File: rtl/pcxt_glue_top.sv
// Top level of the PC/XT board glue, wiring input, sequencer, tint, mixer and output stages
`timescale 1ns/10ps
`include "pcxt_consts.svh"

module pcxt_glue_top #(
	parameter int hold_cycles   = `RESET_HOLD_CYCLES,
	parameter int ticks_per_sec = `SPLASH_TICKS_PER_SEC
) (
	input  logic                            CLK_50M,
	input  logic                            reset_wire,
	input  logic [31:0]                     status,
	input  logic                            ps2_clk,
	input  logic                            ps2_data,
	input  pcxt_video_pkg::pixel_t          pixel,
	input  pcxt_video_pkg::video_sync_t     sync,
	input  pcxt_system_pkg::audio_sources_t sources,
	output pcxt_video_pkg::vga_out_t        vga,
	output pcxt_system_pkg::audio_sample_t  audio_l,
	output pcxt_system_pkg::audio_sample_t  audio_r,
	output logic [12:0]                     video_arx,
	output logic [12:0]                     video_ary,
	output logic                            sys_reset,
	output logic                            cpu_reset,
	output logic                            splash_active,
	output logic                            ps2_clk_sync,
	output logic                            ps2_data_sync
);

	// Pixels and audio take 2 cycles, options 3
	pcxt_system_pkg::pcxt_options_t options;
	pcxt_video_pkg::pixel_t         tint_pixel;
	pcxt_video_pkg::video_sync_t    tint_sync;
	logic signed [16:0]             mix;

	host_input_stage u_host_input_stage (
		.CLK_50M       (CLK_50M),
		.reset_wire    (reset_wire),
		.status        (status),
		.ps2_clk       (ps2_clk),
		.ps2_data      (ps2_data),
		.options       (options),
		.ps2_clk_sync  (ps2_clk_sync),
		.ps2_data_sync (ps2_data_sync)
	);

	power_on_sequencer #(
		.hold_cycles   (hold_cycles),
		.ticks_per_sec (ticks_per_sec)
	) u_power_on_sequencer (
		.CLK_50M       (CLK_50M),
		.reset_wire    (reset_wire),
		.options       (options),
		.sys_reset     (sys_reset),
		.cpu_reset     (cpu_reset),
		.splash_active (splash_active)
	);

	luma_tint u_luma_tint (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.pixel      (pixel),
		.sync       (sync),
		.options    (options),
		.pixel_out  (tint_pixel),
		.sync_out   (tint_sync)
	);

	audio_mixer u_audio_mixer (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.sources    (sources),
		.mix        (mix)
	);

	av_output_stage u_av_output_stage (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.pixel      (tint_pixel),
		.sync       (tint_sync),
		.mix        (mix),
		.options    (options),
		.vga        (vga),
		.audio_l    (audio_l),
		.audio_r    (audio_r),
		.video_arx  (video_arx),
		.video_ary  (video_ary)
	);

endmodule

// File: bench/pcxt_glue_assertions.sv
// Bound checker for the PC/XT glue top, comparing its outputs with rule-based expected values
`timescale 1ns/10ps
`include "pcxt_consts.svh"

module pcxt_glue_assertions (
	input logic                            CLK_50M,
	input logic                            reset_wire,
	input logic [31:0]                     status,
	input logic                            ps2_clk,
	input logic                            ps2_data,
	input pcxt_video_pkg::pixel_t          pixel,
	input pcxt_video_pkg::video_sync_t     sync,
	input pcxt_system_pkg::audio_sources_t sources,
	input pcxt_video_pkg::vga_out_t        vga,
	input pcxt_system_pkg::audio_sample_t  audio_l,
	input pcxt_system_pkg::audio_sample_t  audio_r,
	input logic [12:0]                     video_arx,
	input logic [12:0]                     video_ary,
	input logic                            sys_reset,
	input logic                            cpu_reset,
	input logic                            splash_active,
	input logic                            ps2_clk_sync,
	input logic                            ps2_data_sync
);

	localparam int pad_bits = `VGA_BITS - `COLOR_BITS;

	// Read by the bench at the end of the run
	int error_count = 0;

	// Input history, one tap per cycle
	pcxt_video_pkg::pixel_t          pixel_d1;
	pcxt_video_pkg::pixel_t          pixel_d2;
	pcxt_video_pkg::video_sync_t     sync_d1;
	pcxt_video_pkg::video_sync_t     sync_d2;
	pcxt_system_pkg::audio_sources_t sources_d1;
	pcxt_system_pkg::audio_sources_t sources_d2;
	logic [31:0]                     status_d1;
	logic [31:0]                     status_d2;
	logic [31:0]                     status_d3;
	logic [1:0]                      ps2_d1;
	logic [1:0]                      ps2_d2;
	logic                            reset_d1;

	// Edges since reset_wire fell, saturates at 3
	logic [1:0] run_cycles;

	// Expected outputs
	logic [23:0]                    vga_exp;
	pcxt_system_pkg::audio_sample_t audio_exp;
	logic [12:0]                    arx_exp;
	logic [12:0]                    ary_exp;

	////////////////////////////////////////////////////////////////////////////
	// Reference rules
	////////////////////////////////////////////////////////////////////////////

	// Sum of rounded weighted terms
	function automatic logic [5:0] luma_of(input pcxt_video_pkg::pixel_t p);
		int sum;
		sum = ((int'(p.r) * `LUMA_WEIGHT_R + 127) >> 8)
			+ ((int'(p.g) * `LUMA_WEIGHT_G + 127) >> 8)
			+ ((int'(p.b) * `LUMA_WEIGHT_B + 127) >> 8);
		return sum[5:0];
	endfunction

	// Tint from status bits, MDA bypass, then widened to VGA
	function automatic logic [23:0] tinted_vga(input pcxt_video_pkg::pixel_t p,
		input logic [31:0] st);
		pcxt_video_pkg::pixel_t t;
		logic [5:0]             y;
		t = p;
		y = luma_of(p);
		if (st[4:3] != 2'd2) begin
			case (pcxt_video_pkg::tint_e'(st[2:1]))
				pcxt_video_pkg::green: begin
					t.r = '0;
					t.g = y;
					t.b = '0;
				end
				pcxt_video_pkg::amber: begin
					t.r = y;
					t.g = y >> 1;
					t.b = '0;
				end
				pcxt_video_pkg::mono: begin
					t.r = y;
					t.g = y;
					t.b = y;
				end
				default: t = p;
			endcase
		end
		return {t.r, {pad_bits{1'b0}}, t.g, {pad_bits{1'b0}}, t.b, {pad_bits{1'b0}}};
	endfunction

	// 17-bit wrapped sum, halved
	function automatic pcxt_system_pkg::audio_sample_t half_mix(
		input pcxt_system_pkg::audio_sources_t s);
		int          total;
		logic [16:0] wrapped;
		total   = 4 * int'($signed(s.opl2)) + 32768 * int'(s.speaker) + 64 * int'(s.tandy);
		wrapped = total[16:0];
		return wrapped[16:1];
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// History and expected values
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			run_cycles <= '0;
		end else if (run_cycles != 2'd3) begin
			run_cycles <= run_cycles + 1'b1;
		end
	end

	always_ff @(posedge CLK_50M) begin
		reset_d1   <= reset_wire;
		pixel_d1   <= pixel;
		pixel_d2   <= pixel_d1;
		sync_d1    <= sync;
		sync_d2    <= sync_d1;
		sources_d1 <= sources;
		sources_d2 <= sources_d1;
		status_d1  <= status;
		status_d2  <= status_d1;
		status_d3  <= status_d2;
		ps2_d1     <= {ps2_clk, ps2_data};
		ps2_d2     <= ps2_d1;
	end

	// Pixel 2 cycles back, options one cycle more
	assign vga_exp   = tinted_vga(pixel_d2, status_d3);
	assign audio_exp = half_mix(sources_d2);

	// Field 0 is 4:3
	always_comb begin
		if (status_d2[9:8] == 2'd0) begin
			arx_exp = 13'd4;
			ary_exp = 13'd3;
		end else begin
			arx_exp = 13'(status_d2[9:8]) - 13'd1;
			ary_exp = '0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Assertions
	////////////////////////////////////////////////////////////////////////////

	a_vga_pixel: assert property (@(posedge CLK_50M)
		run_cycles == 2'd3 |-> {vga.r, vga.g, vga.b} == vga_exp)
	else begin
		error_count++;
		$error("[FAIL] vga_pixel expected %h actual %h", $sampled(vga_exp),
			$sampled({vga.r, vga.g, vga.b}));
	end

	a_vga_sync: assert property (@(posedge CLK_50M)
		run_cycles >= 2'd2 |-> vga.sync == sync_d2)
	else begin
		error_count++;
		$error("[FAIL] vga_sync expected %b actual %b", $sampled(sync_d2), $sampled(vga.sync));
	end

	a_audio: assert property (@(posedge CLK_50M)
		run_cycles >= 2'd2 |-> audio_l == audio_exp && audio_r == audio_exp)
	else begin
		error_count++;
		$error("[FAIL] audio expected %h actual %h %h", $sampled(audio_exp),
			$sampled(audio_l), $sampled(audio_r));
	end

	a_aspect: assert property (@(posedge CLK_50M)
		run_cycles >= 2'd2 |-> video_arx == arx_exp && video_ary == ary_exp)
	else begin
		error_count++;
		$error("[FAIL] aspect expected %0d:%0d actual %0d:%0d", $sampled(arx_exp),
			$sampled(ary_exp), $sampled(video_arx), $sampled(video_ary));
	end

	a_ps2: assert property (@(posedge CLK_50M)
		run_cycles >= 2'd2 |-> {ps2_clk_sync, ps2_data_sync} == ps2_d2)
	else begin
		error_count++;
		$error("[FAIL] ps2_sync expected %b actual %b", $sampled(ps2_d2),
			$sampled({ps2_clk_sync, ps2_data_sync}));
	end

	// Second cycle of reset onward
	a_reset_state: assert property (@(posedge CLK_50M)
		reset_wire && reset_d1 |-> sys_reset && cpu_reset && splash_active
			&& vga == '0 && audio_l == '0 && audio_r == '0
			&& video_arx == 13'd4 && video_ary == 13'd3
			&& !ps2_clk_sync && !ps2_data_sync)
	else begin
		error_count++;
		$error("Outputs left their reset state while reset_wire was high");
	end

	a_splash_holds_reset: assert property (@(posedge CLK_50M)
		splash_active |-> sys_reset)
	else begin
		error_count++;
		$error("System reset dropped while the splash screen was still active");
	end

endmodule

// File: bench/pcxt_glue_tb.sv
// Testbench for the PC/XT glue top, driving reset, options and random AV stimulus
`timescale 1ns/10ps
`include "pcxt_consts.svh"

module pcxt_glue_tb;

	// Short counts so the sequencer runs in a few hundred cycles
	localparam int hold_cycles    = 20;
	localparam int ticks_per_sec  = 10;
	localparam int splash_cycles  = `SPLASH_SECONDS * ticks_per_sec;
	localparam int vector_budget  = 400;
	localparam int timeout_cycles = splash_cycles
		+ 3 * (hold_cycles + `CPU_RESET_DELAY) + vector_budget + 200;

	logic                            CLK_50M;
	logic                            reset_wire;
	logic [31:0]                     status;
	logic                            ps2_clk;
	logic                            ps2_data;
	pcxt_video_pkg::pixel_t          pixel;
	pcxt_video_pkg::video_sync_t     sync;
	pcxt_system_pkg::audio_sources_t sources;
	pcxt_video_pkg::vga_out_t        vga;
	pcxt_system_pkg::audio_sample_t  audio_l;
	pcxt_system_pkg::audio_sample_t  audio_r;
	logic [12:0]                     video_arx;
	logic [12:0]                     video_ary;
	logic                            sys_reset;
	logic                            cpu_reset;
	logic                            splash_active;
	logic                            ps2_clk_sync;
	logic                            ps2_data_sync;

	logic [31:0] rng = 32'h1bdf;
	int          cycle_count = 0;
	int          gap_errors = 0;
	int          checker_errors;

	pcxt_glue_top #(
		.hold_cycles   (hold_cycles),
		.ticks_per_sec (ticks_per_sec)
	) dut (
		.CLK_50M       (CLK_50M),
		.reset_wire    (reset_wire),
		.status        (status),
		.ps2_clk       (ps2_clk),
		.ps2_data      (ps2_data),
		.pixel         (pixel),
		.sync          (sync),
		.sources       (sources),
		.vga           (vga),
		.audio_l       (audio_l),
		.audio_r       (audio_r),
		.video_arx     (video_arx),
		.video_ary     (video_ary),
		.sys_reset     (sys_reset),
		.cpu_reset     (cpu_reset),
		.splash_active (splash_active),
		.ps2_clk_sync  (ps2_clk_sync),
		.ps2_data_sync (ps2_data_sync)
	);

	bind pcxt_glue_top pcxt_glue_assertions u_checks (
		.CLK_50M       (CLK_50M),
		.reset_wire    (reset_wire),
		.status        (status),
		.ps2_clk       (ps2_clk),
		.ps2_data      (ps2_data),
		.pixel         (pixel),
		.sync          (sync),
		.sources       (sources),
		.vga           (vga),
		.audio_l       (audio_l),
		.audio_r       (audio_r),
		.video_arx     (video_arx),
		.video_ary     (video_ary),
		.sys_reset     (sys_reset),
		.cpu_reset     (cpu_reset),
		.splash_active (splash_active),
		.ps2_clk_sync  (ps2_clk_sync),
		.ps2_data_sync (ps2_data_sync)
	);

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// 0 splash, 1 system reset, 2 CPU reset
	function automatic logic output_level(input int sel);
		case (sel)
			0:       return splash_active;
			1:       return sys_reset;
			default: return cpu_reset;
		endcase
	endfunction

	// Cycles until the chosen level reaches target, checked at the falling edge
	task automatic measure_edge(input string name, input int sel, input logic target,
		input int expected);
		int cycles;
		int limit;
		cycles = 0;
		limit  = 2 * expected + 10;
		do begin
			@(posedge CLK_50M);
			cycles++;
			@(negedge CLK_50M);
		end while (output_level(sel) != target && cycles < limit);
		if (output_level(sel) != target) begin
			gap_errors++;
			$display("%s never changed within %0d cycles", name, limit);
		end else if (cycles != expected) begin
			gap_errors++;
			$display("[FAIL] %s expected %0d actual %0d", name, expected, cycles);
		end
	endtask

	task automatic apply_reset(input int cycles);
		@(posedge CLK_50M);
		reset_wire <= 1'b1;
		repeat (cycles) @(posedge CLK_50M);
		reset_wire <= 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Clock, random AV stimulus, watchdog
	////////////////////////////////////////////////////////////////////////////

	initial begin
		CLK_50M = 1'b0;
		forever #10 CLK_50M = ~CLK_50M;
	end

	// Pixels, sync, PS/2 and sound samples change every cycle
	initial begin
		pixel    = '0;
		sync     = '0;
		sources  = '0;
		ps2_clk  = 1'b0;
		ps2_data = 1'b0;
		forever begin
			@(posedge CLK_50M);
			rng = lcg_next(rng);
			pixel    <= rng[31:14];
			sync     <= rng[13:11];
			ps2_clk  <= rng[10];
			ps2_data <= rng[9];
			rng = lcg_next(rng);
			sources  <= {rng[31:16], rng[15], rng[14:7]};
		end
	end

	always @(posedge CLK_50M) begin
		cycle_count++;
		if (cycle_count >= timeout_cycles) begin
			$display("Timeout after %0d cycles, the test sequence did not finish", cycle_count);
			$display("sim failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		reset_wire = 1'b1;
		status     = '0;
		repeat (5) @(posedge CLK_50M);
		reset_wire <= 1'b0;

		// Power-on with the full splash
		measure_edge("splash_active fall", 0, 1'b0, splash_cycles);
		measure_edge("sys_reset fall", 1, 1'b0, hold_cycles);
		measure_edge("cpu_reset fall", 2, 1'b0, `CPU_RESET_DELAY);

		// Host reset bit, one extra cycle through the option register
		@(posedge CLK_50M);
		status <= 32'h0000_0001;
		measure_edge("sys_reset rise", 1, 1'b1, 2);
		measure_edge("cpu_reset rise", 2, 1'b1, 1);
		repeat (5) @(posedge CLK_50M);
		status <= 32'h0000_0000;
		measure_edge("sys_reset fall after request", 1, 1'b0, 1 + hold_cycles);
		measure_edge("cpu_reset fall after request", 2, 1'b0, `CPU_RESET_DELAY);

		// Every tint under CGA, Tandy and MDA
		for (int vmode = 0; vmode < 3; vmode++) begin
			for (int tint = 0; tint < 4; tint++) begin
				@(posedge CLK_50M);
				status <= (vmode << 3) | (tint << 1);
				repeat (20) @(posedge CLK_50M);
			end
		end

		// Aspect field sweep
		for (int aspect = 0; aspect < 4; aspect++) begin
			@(posedge CLK_50M);
			status <= aspect << 8;
			repeat (10) @(posedge CLK_50M);
		end

		// Second reset with splash skip set
		@(posedge CLK_50M);
		status <= 32'h0000_0080;
		apply_reset(3);
		measure_edge("splash_active skip", 0, 1'b0, 2);
		measure_edge("sys_reset fall after skip", 1, 1'b0, hold_cycles);
		measure_edge("cpu_reset fall after skip", 2, 1'b0, `CPU_RESET_DELAY);

		repeat (5) @(posedge CLK_50M);
		checker_errors = dut.u_checks.error_count;
		$display("Error counts: %0d assertion, %0d measured gap", checker_errors, gap_errors);
		if (checker_errors == 0 && gap_errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// File: sim.f
+incdir+rtl
rtl/pcxt_system_pkg.sv
rtl/pcxt_video_pkg.sv
rtl/host_input_stage.sv
rtl/power_on_sequencer.sv
rtl/luma_tint.sv
rtl/audio_mixer.sv
rtl/av_output_stage.sv
rtl/pcxt_glue_top.sv
bench/pcxt_glue_assertions.sv
bench/pcxt_glue_tb.sv

// File: Bender.yml
package:
  name: pcxt_glue

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/pcxt_system_pkg.sv
      - rtl/pcxt_video_pkg.sv
      - rtl/host_input_stage.sv
      - rtl/power_on_sequencer.sv
      - rtl/luma_tint.sv
      - rtl/audio_mixer.sv
      - rtl/av_output_stage.sv
      - rtl/pcxt_glue_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/pcxt_glue_assertions.sv
      - bench/pcxt_glue_tb.sv
